// ==== compile.f ====
+incdir+src
+incdir+bench
src/isqrt_pkg.sv
src/isqrt_range_reduce.sv
src/isqrt_skid_buffer.sv
src/isqrt_seed_lut.sv
src/isqrt_nr_stage.sv
src/isqrt_range_augment.sv
src/fixed_isqrt.sv
bench/tb_fixed_isqrt.sv

// ==== run.sh ====
#!/bin/sh
# build the fixed_isqrt testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_fixed_isqrt -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// ==== bench/isqrt_ref.svh ====
`ifndef ISQRT_REF_SVH
`define ISQRT_REF_SVH

// seed for index k: largest r with r*r*(32+k) <= 2**35,
// i.e. floor(2**15 / sqrt(1 + k/32))
function automatic logic [63:0] ref_seed(input logic [`ISQRT_LUT_POW-1:0] k);
    logic [63:0] limit;
    logic [63:0] r;
    logic [63:0] trial;
    limit = 64'd1 << (2 * (`ISQRT_WIDTH - 1) + `ISQRT_LUT_POW);
    r = '0;
    for (int b = `ISQRT_WIDTH - 1; b >= 0; b--) begin
        trial = r | (64'd1 << b);
        if (trial * trial * ((64'd1 << `ISQRT_LUT_POW) + 64'(k)) <= limit) begin
            r = trial;
        end
    end
    return r;
endfunction

// expected Q9.7 value of 1/sqrt(x), truncating at every product
function automatic iq_word_t isqrt_ref(input iq_word_t x);
    int          p;
    int          e;
    int          half;
    logic [63:0] x_norm;
    logic [63:0] y;
    logic [63:0] y_sq;
    logic [63:0] x_y_sq;
    logic [63:0] corr;
    if (x == '0) begin
        return '1;
    end
    p = 0;
    for (int i = 0; i < `ISQRT_WIDTH; i++) begin
        if (x[i]) begin
            p = i;
        end
    end
    // Q1.15 in [1,2)
    x_norm = 64'(x) << (`ISQRT_WIDTH - 1 - p);
    y = ref_seed(x_norm[`ISQRT_WIDTH-2 -: `ISQRT_LUT_POW]);
    // exactly 1.0 keeps the seed
    if (x_norm != (64'd1 << (`ISQRT_WIDTH - 1))) begin
        y_sq   = (y * y) >> (`ISQRT_WIDTH - 1);
        x_y_sq = (x_norm * y_sq) >> (`ISQRT_WIDTH - 1);
        corr   = (64'd3 << (`ISQRT_WIDTH - 1)) - x_y_sq;
        y      = ((y * corr) >> `ISQRT_WIDTH) & ((64'd1 << `ISQRT_WIDTH) - 1);
    end
    e = `ISQRT_FRAC - p;
    if (e % 2 != 0) begin
        // 46341 is sqrt(2) in Q1.15
        y = (y * 64'd46341) >> (`ISQRT_WIDTH - 1);
        e = e - 1;
    end
    half = e / 2;
    if (half >= 0) begin
        y = y << half;
    end else begin
        y = y >> (-half);
    end
    y = y >> (`ISQRT_WIDTH - 1 - `ISQRT_FRAC);
    if (y > ((64'd1 << `ISQRT_WIDTH) - 1)) begin
        return '1;
    end
    return y[`ISQRT_WIDTH-1:0];
endfunction

`endif

// ==== bench/tb_fixed_isqrt.sv ====
`default_nettype none

`include "isqrt_settings.svh"

module tb_fixed_isqrt;

    import isqrt_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int LUT_SIZE     = 1 << `ISQRT_LUT_POW;
    localparam int DIRECTED     = 6 + LUT_SIZE;
    localparam int RAND_ITEMS   = 2000;
    localparam int BP_ITEMS     = 500;
    localparam int BURST_LEN    = 16;
    localparam int PRE_RESET    = 20;
    localparam int POST_RESET   = 50;
    localparam int DRAIN_LIMIT  = 200;
    localparam int TOTAL_ITEMS  = DIRECTED + 1 + RAND_ITEMS + BP_ITEMS + BURST_LEN
                                  + PRE_RESET + POST_RESET;
    localparam int TIMEOUT      = (TOTAL_ITEMS + 50) * CLK_PERIOD * 4;

    logic     clk;
    logic     rst_n;
    iq_word_t in_data;
    logic     in_valid;
    logic     in_ready;
    iq_word_t out_data;
    logic     out_valid;
    logic     out_ready;

    iq_word_t expected_q[$];
    int       seed = 32'hd754;
    int       ready_seed = 32'hd754;
    int       rnd;
    int       ready_rnd;
    logic     throttle_out = 1'b0;
    logic     stall_out = 1'b0;
    int       cycle_count;
    int       accept_cycle;
    int       first_accept;
    int       last_out_cycle;
    int       pass_count = 0;
    int       error_count = 0;
    int       test_errors = 0;

    `include "isqrt_ref.svh"

    fixed_isqrt u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at time %0t: %s got %0h expected %0h", $time, name, got, expected);
            error_count++;
        end else begin
            pass_count++;
        end
    endtask

    // word stays on the bus until in_ready, called just after a falling edge
    task automatic send_item(input iq_word_t value, input iq_word_t expected);
        in_data  = value;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(negedge clk);
        end
        accept_cycle = cycle_count + 1;
        expected_q.push_back(expected);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_ref(input iq_word_t value);
        send_item(value, isqrt_ref(value));
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        check_value("pending_items", 32'(expected_q.size()), 32'd0);
        // a few idle cycles so duplicates show up
        repeat (4) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        $display("test %s done with %0d mismatches", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    // out_ready: low while stalled, random while throttled, else high
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            ready_rnd = $random(ready_seed);
            if (stall_out) begin
                out_ready = 1'b0;
            end else begin
                out_ready = throttle_out ? ready_rnd[0] : 1'b1;
            end
        end
    end

    // scoreboard, one compare per output transfer
    initial begin
        cycle_count    = 0;
        last_out_cycle = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (rst_n && out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("output %h at time %0t arrived with no item pending",
                             out_data, $time);
                    error_count++;
                end else begin
                    check_value("out_data", 32'(out_data), 32'(expected_q.pop_front()));
                    last_out_cycle = cycle_count;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        in_data  = '0;
        in_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Q9.7 1.0, 4.0, 0.25, 2.0, max, min, then 1 + k/32 for every k
        send_ref(16'h0080);
        send_ref(16'h0200);
        send_ref(16'h0020);
        send_ref(16'h0100);
        send_ref(16'hffff);
        send_ref(16'h0001);
        for (int k = 0; k < LUT_SIZE; k++) begin
            send_ref(iq_word_t'((LUT_SIZE + k) << (`ISQRT_FRAC - `ISQRT_LUT_POW)));
        end
        drain_queue();
        report_test("directed");

        send_item(16'h0000, 16'hffff);
        drain_queue();
        report_test("zero input");

        for (int i = 0; i < RAND_ITEMS; i++) begin
            rnd = $random(seed);
            send_ref(rnd[15:0]);
        end
        drain_queue();
        report_test("random stream");

        throttle_out = 1'b1;
        for (int i = 0; i < BP_ITEMS; i++) begin
            rnd = $random(seed);
            if (rnd[16]) begin
                @(negedge clk);
            end
            send_ref(rnd[15:0]);
        end
        drain_queue();
        throttle_out = 1'b0;
        repeat (2) @(negedge clk);
        report_test("back-pressure");

        // back-to-back burst, last output at first accept + N + 3
        for (int i = 0; i < BURST_LEN; i++) begin
            rnd = $random(seed);
            send_ref(rnd[15:0]);
            if (i == 0) begin
                first_accept = accept_cycle;
            end
        end
        drain_queue();
        check_value("burst_cycles", 32'(last_out_cycle - first_accept), 32'(BURST_LEN + 3));
        report_test("burst latency");

        for (int i = 0; i < PRE_RESET; i++) begin
            rnd = $random(seed);
            send_ref(rnd[15:0]);
        end
        // hold the output and keep offering the last word until every slot is full
        stall_out = 1'b1;
        in_valid  = 1'b1;
        repeat (12) @(negedge clk);
        check_value("in_ready", 32'(in_ready), 32'd0);
        in_valid = 1'b0;
        rst_n    = 1'b0;
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        stall_out = 1'b0;
        @(negedge clk);
        rst_n = 1'b1;
        // items still in flight were dropped by reset
        expected_q.delete();
        check_value("in_ready", 32'(in_ready), 32'd1);
        for (int i = 0; i < POST_RESET; i++) begin
            rnd = $random(seed);
            send_ref(rnd[15:0]);
        end
        drain_queue();
        report_test("reset mid-stream");

        $display("checks passed %0d, failed %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/fixed_isqrt.sv ====
`default_nettype none

module fixed_isqrt (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire isqrt_pkg::iq_word_t in_data,
    input  wire                      in_valid,
    output logic                     in_ready,
    output isqrt_pkg::iq_word_t      out_data,
    output logic                     out_valid,
    input  wire                      out_ready
);

    import isqrt_pkg::*;

    reduced_t reduced_0;
    reduced_t reduced_1;
    seeded_t  seeded_1;
    seeded_t  seeded_2;
    refined_t refined_3;
    iq_word_t result_3;

    logic valid_1;
    logic ready_1;
    logic valid_2;
    logic ready_2;
    logic valid_3;
    logic ready_3;

    // stage 1, normalize to [1,2)
    isqrt_range_reduce u_reduce (
        .data    (in_data),
        .reduced (reduced_0)
    );

    isqrt_skid_buffer #(
        .DATA_WIDTH ($bits(reduced_t))
    ) skid_0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (reduced_0),
        .valid_in  (in_valid),
        .ready_in  (in_ready),
        .data_out  (reduced_1),
        .valid_out (valid_1),
        .ready_out (ready_1)
    );

    // stage 2, seed lookup
    isqrt_seed_lut u_seed (
        .reduced (reduced_1),
        .seeded  (seeded_1)
    );

    isqrt_skid_buffer #(
        .DATA_WIDTH ($bits(seeded_t))
    ) skid_1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (seeded_1),
        .valid_in  (valid_1),
        .ready_in  (ready_1),
        .data_out  (seeded_2),
        .valid_out (valid_2),
        .ready_out (ready_2)
    );

    // stage 3, one Newton-Raphson step with its own register
    isqrt_nr_stage u_nr (
        .clk       (clk),
        .rst_n     (rst_n),
        .seeded    (seeded_2),
        .valid_in  (valid_2),
        .ready_in  (ready_2),
        .refined   (refined_3),
        .valid_out (valid_3),
        .ready_out (ready_3)
    );

    // stage 4, restore exponent and map to Q9.7
    isqrt_range_augment u_augment (
        .refined (refined_3),
        .result  (result_3)
    );

    isqrt_skid_buffer #(
        .DATA_WIDTH ($bits(iq_word_t))
    ) skid_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (result_3),
        .valid_in  (valid_3),
        .ready_in  (ready_3),
        .data_out  (out_data),
        .valid_out (out_valid),
        .ready_out (out_ready)
    );

endmodule

`default_nettype wire

// ==== src/isqrt_range_augment.sv ====
`default_nettype none

`include "isqrt_settings.svh"

module isqrt_range_augment (
    input  wire isqrt_pkg::refined_t refined,
    output isqrt_pkg::iq_word_t      result
);

    import isqrt_pkg::*;

    localparam int W = `ISQRT_WIDTH;
    localparam int F = `ISQRT_FRAC;
    // Q1.15 down to Q9.7
    localparam int OUT_SHIFT = (W - 1) - F;
    localparam logic [2*W-1:0] MAX_WORD = (2*W)'({W{1'b1}});

    logic signed [5:0] e_raw;
    logic signed [5:0] e_even;
    logic signed [5:0] half_e;
    logic [2*W-1:0]    y_adj;
    logic [2*W-1:0]    y_shift;
    logic [2*W-1:0]    y_out;

    always_comb begin
        // exponent of the input relative to 1.0
        e_raw = $signed(6'(F)) - $signed({2'b00, refined.red.msb_idx});
        if (e_raw[0]) begin
            // odd exponent, fold one factor of sqrt(2) into y
            y_adj  = ((2*W)'(refined.y) * (2*W)'(SQRT2_Q)) >> (W - 1);
            e_even = e_raw - 6'sd1;
        end else begin
            y_adj  = (2*W)'(refined.y);
            e_even = e_raw;
        end
        half_e = e_even >>> 1;
        if (half_e >= 0) begin
            y_shift = y_adj << $unsigned(half_e);
        end else begin
            y_shift = y_adj >> $unsigned(-half_e);
        end
        y_out = y_shift >> OUT_SHIFT;
    end

    // zero maps to the largest word, as does any overflow
    always_comb begin
        if (refined.red.is_zero || (y_out > MAX_WORD)) begin
            result = '1;
        end else begin
            result = y_out[W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== src/isqrt_nr_stage.sv ====
`default_nettype none

`include "isqrt_settings.svh"

module isqrt_nr_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire isqrt_pkg::seeded_t seeded,
    input  wire                     valid_in,
    output logic                    ready_in,
    output isqrt_pkg::refined_t     refined,
    output logic                    valid_out,
    input  wire                     ready_out
);

    import isqrt_pkg::*;

    localparam int W = `ISQRT_WIDTH;
    localparam int F = W - 1;

    localparam logic [2*W-1:0] THREE_Q = 3 << F;

    logic [2*W-1:0] y0;
    logic [2*W-1:0] x;
    logic [2*W-1:0] y0_sq;
    logic [2*W-1:0] x_y0_sq;
    logic [2*W-1:0] corr;
    logic [2*W-1:0] y1_full;
    iq_word_t       y1;

    // y1 = y0 * (3 - x * y0^2) / 2, all Q1.15 with truncation
    assign y0      = (2*W)'(seeded.seed);
    assign x       = (2*W)'(seeded.red.x_norm);
    assign y0_sq   = (y0 * y0) >> F;
    assign x_y0_sq = (x * y0_sq) >> F;
    assign corr    = THREE_Q - x_y0_sq;
    // extra bit of shift is the divide by two
    assign y1_full = (y0 * corr) >> (F + 1);

    // x = 1.0 with seed 1.0 is a fixed point of the step
    assign y1 = y1_full[W-1:0];

    // take a new item when empty or being drained
    assign ready_in = ~valid_out | ready_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (ready_in) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in && ready_in) begin
            refined.red <= seeded.red;
            refined.y   <= y1;
        end
    end

endmodule

`default_nettype wire

// ==== src/isqrt_seed_lut.sv ====
`default_nettype none

`include "isqrt_settings.svh"

module isqrt_seed_lut (
    input  wire isqrt_pkg::reduced_t reduced,
    output isqrt_pkg::seeded_t       seeded
);

    import isqrt_pkg::*;

    localparam int W        = `ISQRT_WIDTH;
    localparam int LUT_POW  = `ISQRT_LUT_POW;
    localparam int LUT_SIZE = 1 << LUT_POW;

    // entry k = floor(2**15 / sqrt(1 + k/32)), computed as
    // floor(sqrt(2**30 * 32 / (32 + k))) with integers only
    function automatic logic [LUT_SIZE*W-1:0] build_table();
        logic [LUT_SIZE*W-1:0] table_bits;
        logic [63:0]           num;
        logic [63:0]           root;
        logic [63:0]           trial;
        table_bits = '0;
        for (int k = 0; k < LUT_SIZE; k++) begin
            num  = (64'd1 << (2 * (W - 1) + LUT_POW)) / (64'(LUT_SIZE) + 64'(k));
            root = '0;
            // bitwise integer square root
            for (int b = 31; b >= 0; b--) begin
                trial = root | (64'd1 << b);
                if (trial * trial <= num) begin
                    root = trial;
                end
            end
            table_bits[k*W +: W] = root[W-1:0];
        end
        return table_bits;
    endfunction

    localparam logic [LUT_SIZE*W-1:0] SEED_TABLE = build_table();

    logic [LUT_POW-1:0] k;

    // bits just below the leading one of x_norm
    assign k = reduced.x_norm[W-2 -: LUT_POW];

    always_comb begin
        seeded.red  = reduced;
        seeded.seed = SEED_TABLE[k*W +: W];
    end

endmodule

`default_nettype wire

// ==== src/isqrt_skid_buffer.sv ====
`default_nettype none

module isqrt_skid_buffer #(
    parameter int DATA_WIDTH = 16
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  [DATA_WIDTH-1:0] data_in,
    input  wire                   valid_in,
    output logic                  ready_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid_out,
    input  wire                   ready_out
);

    logic [DATA_WIDTH-1:0] skid_data;
    logic                  skid_valid;

    // ready comes straight from a flop
    assign ready_in = ~skid_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            // both entries full, wait for the consumer
            if (ready_out) begin
                valid_out  <= 1'b1;
                skid_valid <= 1'b0;
            end
        end else if (!valid_out || ready_out) begin
            valid_out <= valid_in;
        end else if (valid_in) begin
            // item in transit while the output is stalled
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_valid) begin
            if (ready_out) begin
                data_out <= skid_data;
            end
        end else if (!valid_out || ready_out) begin
            if (valid_in) begin
                data_out <= data_in;
            end
        end else if (valid_in) begin
            skid_data <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/isqrt_range_reduce.sv ====
`default_nettype none

module isqrt_range_reduce (
    input  wire isqrt_pkg::iq_word_t data,
    output isqrt_pkg::reduced_t      reduced
);

    import isqrt_pkg::*;

    localparam int W = $bits(iq_word_t);

    msb_idx_t msb;
    msb_idx_t shift;

    // leading-one detector, highest set bit wins
    always_comb begin
        msb = '0;
        for (int i = 0; i < W; i++) begin
            if (data[i]) begin
                msb = msb_idx_t'(i);
            end
        end
    end

    // move the leading one up to bit W-1
    assign shift = msb_idx_t'(W - 1) - msb;

    always_comb begin
        reduced.x_norm  = data << shift;
        reduced.msb_idx = msb;
        // zero input leaves msb and x_norm at zero
        reduced.is_zero = (data == '0);
    end

endmodule

`default_nettype wire

// ==== src/isqrt_pkg.sv ====
`default_nettype none

`include "isqrt_settings.svh"

package isqrt_pkg;

    // data word, Q9.7 at the ports and Q1.15 inside the pipeline
    typedef logic [`ISQRT_WIDTH-1:0] iq_word_t;

    // position of the leading one in the input word
    typedef logic [$clog2(`ISQRT_WIDTH)-1:0] msb_idx_t;

    // output of range reduction, x_norm is Q1.15 in [1,2)
    typedef struct packed {
        iq_word_t x_norm;
        msb_idx_t msb_idx;
        logic     is_zero;
    } reduced_t;

    // reduced operand with the table seed attached
    typedef struct packed {
        reduced_t red;
        iq_word_t seed;
    } seeded_t;

    // reduced operand with the refined estimate, y is Q1.15
    typedef struct packed {
        reduced_t red;
        iq_word_t y;
    } refined_t;

    // sqrt(2) in Q1.15
    localparam iq_word_t SQRT2_Q = 16'd46341;

endpackage

`default_nettype wire

// ==== src/isqrt_settings.svh ====
`ifndef ISQRT_SETTINGS_SVH
`define ISQRT_SETTINGS_SVH

// word width of the Q9.7 data path
`define ISQRT_WIDTH 16

// fraction bits of input and output words
`define ISQRT_FRAC 7

// seed table index bits, 2**5 = 32 entries
`define ISQRT_LUT_POW 5

`endif
